// ==== sources.f ====
+incdir+hdl
hdl/mvm_pkg.sv
hdl/vector_mac.sv
hdl/operand_store.sv
hdl/row_sequencer.sv
hdl/mvm_top.sv
sim/mvm_checker.sv
sim/mvm_tb.sv

// ==== sim/mvm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

module mvm_tb;

    logic               clk;
    logic               rst;
    logic               wr_en;
    mvm_pkg::load_req_t wr_req;
    logic               go;
    logic               busy;
    logic               done;
    mvm_pkg::row_addr_t rd_addr;
    mvm_pkg::result_t   rd_data;

    mvm_pkg::vec_t rows_m [`MVM_ROWS];  // model copy of the row store
    mvm_pkg::vec_t vec_m;
    logic [31:0]   rng;

    mvm_top uut (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_req  (wr_req),
        .go      (go),
        .busy    (busy),
        .done    (done),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // signed sum of element-wise products
    function automatic mvm_pkg::result_t dot_model(input mvm_pkg::vec_t row,
                                                   input mvm_pkg::vec_t v);
        int sum;
        sum = 0;
        for (int i = 0; i < `MVM_VECTOR_SIZE; i++) begin
            sum += int'($signed(row[i])) * int'($signed(v[i]));
        end
        return mvm_pkg::result_t'(sum);
    endfunction

    function automatic mvm_pkg::vec_t pack_elems(input int e0, input int e1, input int e2,
                                                 input int e3, input int e4);
        mvm_pkg::vec_t v;
        v[0] = 8'(e0);
        v[1] = 8'(e1);
        v[2] = 8'(e2);
        v[3] = 8'(e3);
        v[4] = 8'(e4);
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_result(input mvm_pkg::result_t act, input mvm_pkg::result_t exp,
                                input string name);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic random_vec(output mvm_pkg::vec_t v);
        for (int i = 0; i < `MVM_VECTOR_SIZE; i++) begin
            rng  = xorshift32(rng);
            v[i] = rng[7:0];
        end
    endtask

    // one write cycle, entered and left just after a falling edge
    task automatic drive_write(input mvm_pkg::load_req_t req);
        wr_en  = 1'b1;
        wr_req = req;
        @(negedge clk);
        wr_en  = 1'b0;
    endtask

    task automatic write_row(input int addr, input mvm_pkg::vec_t data);
        mvm_pkg::load_req_t req;
        req.target = mvm_pkg::WR_ROW;
        req.addr   = mvm_pkg::row_addr_t'(addr);
        req.data   = data;
        drive_write(req);
        rows_m[addr] = data;
    endtask

    task automatic set_vector(input mvm_pkg::vec_t data);
        mvm_pkg::load_req_t req;
        req.target = mvm_pkg::WR_VEC;
        req.addr   = mvm_pkg::row_addr_t'(3);  // ignored by the store
        req.data   = data;
        drive_write(req);
        vec_m = data;
    endtask

    task automatic pulse_go();
        go = 1'b1;
        @(negedge clk);
        go = 1'b0;
        check_flag(busy, 1'b1, "busy");
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles >= 100) begin
                $display("timeout after %0d cycles, done never arrived", cycles);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
        check_flag(busy, 1'b0, "busy");
        @(negedge clk);
        check_flag(done, 1'b0, "done");  // one-cycle pulse
    endtask

    // read every slot back and compare with the model
    task automatic compare_results();
        for (int r = 0; r < `MVM_ROWS; r++) begin
            rd_addr = mvm_pkg::row_addr_t'(r);
            @(negedge clk);
            check_result(rd_data, dot_model(rows_m[r], vec_m), $sformatf("rd_data[%0d]", r));
        end
    endtask

    task automatic reset_state();
        check_flag(busy, 1'b0, "busy");
        check_flag(done, 1'b0, "done");
        for (int r = 0; r < `MVM_ROWS; r++) begin
            rd_addr = mvm_pkg::row_addr_t'(r);
            @(negedge clk);
            check_result(rd_data, '0, $sformatf("rd_data[%0d]", r));
        end
    endtask

    task automatic directed_rows();
        set_vector(pack_elems(1, -2, 3, -4, 5));
        write_row(0, pack_elems(1, 2, 3, 4, 5));
        write_row(1, pack_elems(0, 0, 0, 0, 0));
        write_row(2, pack_elems(-3, 7, -1, 2, -6));
        write_row(3, pack_elems(0, 0, 0, 0, -7));  // only the tail chunk counts
        pulse_go();
        wait_done();
        compare_results();
    endtask

    task automatic signed_extremes();
        set_vector(pack_elems(-128, -128, -128, -128, -128));
        write_row(0, pack_elems(-128, -128, -128, -128, -128));
        write_row(1, pack_elems(-128, -128, -128, -128, -128));
        write_row(2, pack_elems(127, 127, 127, 127, 127));
        write_row(3, pack_elems(127, -128, 127, -128, 127));
        pulse_go();
        wait_done();
        compare_results();
    endtask

    task automatic random_matrix();
        mvm_pkg::vec_t v;
        for (int r = 0; r < `MVM_ROWS; r++) begin
            random_vec(v);
            write_row(r, v);
        end
        random_vec(v);
        set_vector(v);
        pulse_go();
        wait_done();
        compare_results();
        random_vec(v);  // new vector, same rows
        set_vector(v);
        pulse_go();
        wait_done();
        compare_results();
    endtask

    task automatic busy_writes();
        mvm_pkg::load_req_t req;
        req.target = mvm_pkg::WR_ROW;
        req.addr   = mvm_pkg::row_addr_t'(1);
        req.data   = pack_elems(100, 100, 100, 100, 100);
        pulse_go();
        drive_write(req);  // lands while busy, model untouched
        go = 1'b1;         // extra go while busy
        @(negedge clk);
        go = 1'b0;
        wait_done();
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            check_flag(done, 1'b0, "done");
        end
        compare_results();
        pulse_go();
        wait_done();
        compare_results();
        write_row(1, req.data);  // idle now, so this one takes
        pulse_go();
        wait_done();
        compare_results();
    endtask

    initial begin
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_req  = '0;
        go      = 1'b0;
        rd_addr = '0;
        rng     = 32'h1fd0_2e18;
        vec_m   = '0;
        for (int r = 0; r < `MVM_ROWS; r++) begin
            rows_m[r] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_state();
        directed_rows();
        signed_extremes();
        random_matrix();
        busy_writes();

        if (uut.u_seq.u_checker.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures in the sequencer", uut.u_seq.u_checker.fail_count);
            $display("tests failed");
            $fatal(1, "assertion failures during the run");
        end
    end

endmodule

`default_nettype wire

// ==== sim/mvm_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol assertions on the row sequencer
module mvm_checker (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                busy,
    input  wire logic                done,
    input  wire logic                mac_start,
    input  wire mvm_pkg::seq_state_e state
);

    int unsigned fail_count = 0;  // read by the testbench at the end of the run

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
    else begin
        $error("done held high for more than one cycle");
        fail_count++;
    end

    // busy was high on the row before and is low with done
    done_drops_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> (!busy && $past(busy)))
    else begin
        $error("done without busy falling");
        fail_count++;
    end

    // a start lasts one cycle and the row then waits in the MAC
    start_then_wait: assert property (@(posedge clk) disable iff (rst)
        mac_start |=> (state == mvm_pkg::SEQ_WAIT))
    else begin
        $error("mac_start not followed by SEQ_WAIT");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk)
        rst |=> !busy)
    else begin
        $error("busy high in the cycle after reset");
        fail_count++;
    end

endmodule

bind row_sequencer mvm_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .done      (done),
    .mac_start (mac_start),
    .state     (state)
);

`default_nettype wire

// ==== hdl/mvm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

// matrix-vector multiply engine
module mvm_top (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               wr_en,
    input  wire mvm_pkg::load_req_t wr_req,
    input  wire logic               go,
    output logic                    busy,
    output logic                    done,
    input  wire mvm_pkg::row_addr_t rd_addr,
    output mvm_pkg::result_t        rd_data
);

    mvm_pkg::row_addr_t row_sel;
    mvm_pkg::vec_t      row_data;
    mvm_pkg::vec_t      vec_data;
    logic               mac_start;
    logic               mac_valid;
    mvm_pkg::result_t   mac_result;

    operand_store u_store (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_req   (wr_req),
        .busy     (busy),
        .row_sel  (row_sel),
        .row_data (row_data),
        .vec_data (vec_data)
    );

    row_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .go         (go),
        .busy       (busy),
        .done       (done),
        .row_sel    (row_sel),
        .mac_start  (mac_start),
        .mac_valid  (mac_valid),
        .mac_result (mac_result),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // a is the row, b the vector; both 40 bits flat
    vector_mac #(
        .VECTOR_SIZE (`MVM_VECTOR_SIZE),
        .WIDTH1      (`MVM_ELEM_WIDTH),
        .WIDTH2      (`MVM_ELEM_WIDTH),
        .TILING      (`MVM_TILING)
    ) u_mac (
        .clk    (clk),
        .rst    (rst),
        .start  (mac_start),
        .a      (row_data),
        .b      (vec_data),
        .result (mac_result),
        .valid  (mac_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/row_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

// runs each row through the MAC and collects the results
module row_sequencer (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               go,
    output logic                    busy,
    output logic                    done,
    output mvm_pkg::row_addr_t      row_sel,
    output logic                    mac_start,
    input  wire logic               mac_valid,
    input  wire mvm_pkg::result_t   mac_result,
    input  wire mvm_pkg::row_addr_t rd_addr,
    output mvm_pkg::result_t        rd_data
);

    mvm_pkg::seq_state_e state;
    mvm_pkg::row_addr_t  row_cnt;
    mvm_pkg::result_t    results [`MVM_ROWS];
    logic                capture;
    logic                last_row;

    assign capture  = (state == mvm_pkg::SEQ_WAIT) && mac_valid;
    assign last_row = (row_cnt == mvm_pkg::row_addr_t'(`MVM_ROWS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mvm_pkg::SEQ_IDLE;
            row_cnt <= '0;
        end else begin
            case (state)
                mvm_pkg::SEQ_IDLE: begin
                    if (go) begin
                        state   <= mvm_pkg::SEQ_START;
                        row_cnt <= '0;
                    end
                end
                mvm_pkg::SEQ_START: begin
                    state <= mvm_pkg::SEQ_WAIT;  // MAC has taken the start
                end
                mvm_pkg::SEQ_WAIT: begin
                    if (mac_valid) begin
                        if (last_row) begin
                            state   <= mvm_pkg::SEQ_DONE;
                            row_cnt <= '0;
                        end else begin
                            state   <= mvm_pkg::SEQ_START;
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end
                end
                mvm_pkg::SEQ_DONE: begin
                    state <= mvm_pkg::SEQ_IDLE;
                end
                default: state <= mvm_pkg::SEQ_IDLE;
            endcase
        end
    end

    // result file, a slot keeps its value until a later run rewrites it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `MVM_ROWS; r++) begin
                results[r] <= '0;
            end
        end else if (capture) begin
            results[row_cnt] <= mac_result;
        end
    end

    assign busy      = (state == mvm_pkg::SEQ_START) || (state == mvm_pkg::SEQ_WAIT);
    assign done      = (state == mvm_pkg::SEQ_DONE);  // busy already low here
    assign mac_start = (state == mvm_pkg::SEQ_START);
    assign row_sel   = row_cnt;

    assign rd_data = results[rd_addr];

endmodule

`default_nettype wire

// ==== hdl/operand_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

// matrix rows and the shared vector, loaded by the host
module operand_store (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               wr_en,
    input  wire mvm_pkg::load_req_t wr_req,
    input  wire logic               busy,
    input  wire mvm_pkg::row_addr_t row_sel,
    output mvm_pkg::vec_t           row_data,
    output mvm_pkg::vec_t           vec_data
);

    mvm_pkg::vec_t rows [`MVM_ROWS];
    mvm_pkg::vec_t vec_reg;
    logic          wr_ok;

    // operands must not move under the MAC, so writes are lost while busy
    assign wr_ok = wr_en && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `MVM_ROWS; r++) begin
                rows[r] <= '0;
            end
            vec_reg <= '0;
        end else if (wr_ok) begin
            case (wr_req.target)
                mvm_pkg::WR_ROW: rows[wr_req.addr] <= wr_req.data;
                mvm_pkg::WR_VEC: vec_reg <= wr_req.data;   // addr ignored
                default: ;
            endcase
        end
    end

    // combinational read for the sequencer
    assign row_data = rows[row_sel];
    assign vec_data = vec_reg;

endmodule

`default_nettype wire

// ==== hdl/vector_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

// serial signed dot product, TILING products per cycle
module vector_mac #(
    parameter int VECTOR_SIZE = 5,  // elements per vector
    parameter int WIDTH1      = 8,  // element width of a
    parameter int WIDTH2      = 8,  // element width of b
    parameter int TILING      = 2,  // products summed per cycle
    localparam int RESULT_WIDTH = WIDTH1 + WIDTH2 + $clog2(VECTOR_SIZE) + 1
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            start,
    input  wire logic [VECTOR_SIZE*WIDTH1-1:0]   a,
    input  wire logic [VECTOR_SIZE*WIDTH2-1:0]   b,
    output logic signed [RESULT_WIDTH-1:0]       result,
    output logic                                 valid
);

    localparam int MULT_WIDTH = WIDTH1 + WIDTH2;
    localparam int CNT_WIDTH  = $clog2(VECTOR_SIZE) + 1;  // one spare bit for the tail

    mvm_pkg::mac_state_e            state;
    logic [CNT_WIDTH-1:0]           counter;     // index of the first element in the chunk
    logic signed [RESULT_WIDTH-1:0] acc;
    logic signed [RESULT_WIDTH-1:0] sum;         // partial sum of the current chunk
    logic                           valid_buffer;
    logic                           last_chunk;

    // chunk products, indices past the vector end contribute nothing
    // the reduce is a plain adder chain, fine for small TILING
    always_comb begin : chunk_sum
        int idx;
        logic signed [MULT_WIDTH-1:0] prod;
        sum = '0;
        for (int i = 0; i < TILING; i++) begin
            idx  = int'(counter) + i;
            prod = '0;
            if (idx < VECTOR_SIZE) begin
                prod = $signed(a[idx*WIDTH1 +: WIDTH1]) * $signed(b[idx*WIDTH2 +: WIDTH2]);
            end
            sum = sum + prod;
        end
    end

    assign last_chunk = (int'(counter) + TILING >= VECTOR_SIZE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= mvm_pkg::MAC_IDLE;
            counter      <= '0;
            acc          <= '0;
            valid_buffer <= 1'b0;
        end else begin
            case (state)
                mvm_pkg::MAC_IDLE: begin
                    counter <= '0;
                    if (start) begin
                        state        <= mvm_pkg::MAC_RUN;
                        acc          <= '0;    // fresh accumulation
                        valid_buffer <= 1'b0;
                    end
                end
                mvm_pkg::MAC_RUN: begin
                    acc <= acc + sum;
                    if (last_chunk) begin
                        state        <= mvm_pkg::MAC_IDLE;
                        counter      <= '0;
                        valid_buffer <= 1'b1;  // result holds until next start
                    end else begin
                        counter <= counter + CNT_WIDTH'(TILING);
                    end
                end
                default: state <= mvm_pkg::MAC_IDLE;
            endcase
        end
    end

    assign result = acc;
    assign valid  = valid_buffer && !start;  // a new start hides the old result

endmodule

`default_nettype wire

// ==== hdl/mvm_pkg.sv ====
`default_nettype none

package mvm_pkg;

    `include "mvm_consts.svh"

    // element 0 sits in the low bits
    typedef logic [`MVM_VECTOR_SIZE-1:0][`MVM_ELEM_WIDTH-1:0] vec_t;

    typedef logic signed [`MVM_RESULT_WIDTH-1:0] result_t;

    typedef logic [`MVM_ROW_ADDR_WIDTH-1:0] row_addr_t;

    // host write opcode
    typedef enum logic {
        WR_ROW = 1'b0,  // write one matrix row at addr
        WR_VEC = 1'b1   // write the vector register, addr unused
    } wr_target_e;

    // one host write, 43 bits
    typedef struct packed {
        wr_target_e target;
        row_addr_t  addr;
        vec_t       data;
    } load_req_t;

    typedef enum logic {
        MAC_IDLE = 1'b0,
        MAC_RUN  = 1'b1
    } mac_state_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_START = 2'd1,  // mac_start pulse for the current row
        SEQ_WAIT  = 2'd2,  // row in the MAC, capture on valid
        SEQ_DONE  = 2'd3   // one-cycle done pulse
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hdl/mvm_consts.svh ====
`ifndef MVM_CONSTS_SVH
`define MVM_CONSTS_SVH

// engine dimensions
`define MVM_VECTOR_SIZE 5     // elements per vector and per row
`define MVM_ELEM_WIDTH 8      // signed element width
`define MVM_TILING 2          // products summed per MAC cycle
`define MVM_ROWS 4            // matrix rows held in the store
`define MVM_ROW_ADDR_WIDTH 2  // enough bits to index MVM_ROWS

// result width: two element widths, log2 of the vector size, plus one
// 8 + 8 + 3 + 1 for the default sizes
`define MVM_RESULT_WIDTH 20

`endif
